//--- descriptor_calc.sv
module descriptor_calc
  import image_pkg::*;
  import descriptor_pkg::*;
(
    input clk,
    input rst_n_i,
    input window_t win_i,
    input win_valid_i,
    input frame_last_i,
    output code_t ni_o,
    output code_t rd_o,
    output logic desc_valid_o,
    output logic frame_done_o
);

  // uniform patterns map to their count of ones
  function automatic code_t riu2(input pattern_t p);
    pattern_t diff;
    int trans;
    diff  = p ^ {p[0], p[NUM_SAMPLES-1:1]};
    trans = $countones(diff);
    if (trans <= MAX_TRANSITIONS) begin
      return code_t'($countones(p));
    end
    return NONUNIFORM_CODE;
  endfunction

  pixel_t [NUM_SAMPLES-1:0] outer_d;
  pixel_t [NUM_SAMPLES-1:0] inner_d;
  pattern_t rd_pat_d;
  sum_t sum_d;

  pixel_t [NUM_SAMPLES-1:0] outer_q;
  pattern_t rd_pat_q;
  sum_t sum_q;
  logic s1_valid;
  logic s1_last;

  pattern_t ni_pat;

  // ring samples, outer at RADIUS, inner at one
  always_comb begin
    outer_d[0] = win_i[2*RADIUS][RADIUS];
    inner_d[0] = win_i[RADIUS+1][RADIUS];
    outer_d[1] = win_i[2*RADIUS][0];
    inner_d[1] = win_i[RADIUS+1][RADIUS-1];
    outer_d[2] = win_i[RADIUS][0];
    inner_d[2] = win_i[RADIUS][RADIUS-1];
    outer_d[3] = win_i[0][0];
    inner_d[3] = win_i[RADIUS-1][RADIUS-1];
    outer_d[4] = win_i[0][RADIUS];
    inner_d[4] = win_i[RADIUS-1][RADIUS];
    outer_d[5] = win_i[0][2*RADIUS];
    inner_d[5] = win_i[RADIUS-1][RADIUS+1];
    outer_d[6] = win_i[RADIUS][2*RADIUS];
    inner_d[6] = win_i[RADIUS][RADIUS+1];
    outer_d[7] = win_i[2*RADIUS][2*RADIUS];
    inner_d[7] = win_i[RADIUS+1][RADIUS+1];
  end

  always_comb begin
    for (int k = 0; k < NUM_SAMPLES; k++) begin
      rd_pat_d[k] = (outer_d[k] >= inner_d[k]);
    end
  end

  // patch sum over the whole window
  always_comb begin
    sum_d = '0;
    for (int c = 0; c < WIN; c++) begin
      for (int r = 0; r < WIN; r++) begin
        sum_d = sum_d + sum_t'(win_i[c][r]);
      end
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      sum_q    <= sum_d;
      rd_pat_q <= rd_pat_d;
      outer_q  <= outer_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= win_valid_i;
      s1_last  <= win_valid_i && frame_last_i;
    end
  end

  // compare against the mean without dividing
  always_comb begin
    for (int k = 0; k < NUM_SAMPLES; k++) begin
      ni_pat[k] = (sum_t'(outer_q[k]) * sum_t'(WIN_AREA) >= sum_q);
    end
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      ni_o <= riu2(ni_pat);
      rd_o <= riu2(rd_pat_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      desc_valid_o <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      desc_valid_o <= s1_valid;
      frame_done_o <= s1_last;
    end
  end

endmodule

//--- descriptor_pkg.sv
package descriptor_pkg;

  // ring samples, bit 0 east then counter-clockwise
  localparam int NUM_SAMPLES = 8;

  typedef logic [NUM_SAMPLES-1:0] pattern_t;

  // sum of the whole window, 25 x 255 fits in 13 bits
  localparam int SUM_W = 13;

  typedef logic [SUM_W-1:0] sum_t;

  // riu2 code, 0..8 for uniform patterns
  localparam int CODE_W = 4;

  typedef logic [CODE_W-1:0] code_t;

  localparam code_t NONUNIFORM_CODE = 4'd9;

  // a pattern is uniform up to this many circular transitions
  localparam int MAX_TRANSITIONS = 2;

endpackage

//--- image_pkg.sv
package image_pkg;

  // pixel format
  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  // frame geometry
  localparam int COLS = 16;
  localparam int ROWS = 16;
  localparam int COL_W = $clog2(COLS);
  localparam int ROW_W = $clog2(ROWS);

  // window around the centre pixel, outer ring at RADIUS
  localparam int RADIUS = 2;
  localparam int WIN = 2 * RADIUS + 1;
  localparam int WIN_AREA = WIN * WIN;

  // one vertical slice of the window, index 0 is the oldest row
  typedef pixel_t [WIN-1:0] column_t;

  // indexed [column][row], column 0 is the leftmost
  typedef column_t [WIN-1:0] window_t;

endpackage

//--- line_buffer.sv
module line_buffer
  import image_pkg::*;
(
    input clk,
    input rst_n_i,
    input pixel_t pix_i,
    input pix_valid_i,
    output column_t col_o,
    output logic col_valid_o,
    output logic win_full_o,
    output logic last_o
);

  // four past rows, row_mem[0] is the oldest
  pixel_t row_mem[WIN-1][COLS];

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic col_end;
  logic row_end;
  logic win_full;

  assign col_end = (col_cnt == COL_W'(COLS - 1));
  assign row_end = (row_cnt == ROW_W'(ROWS - 1));

  // enough rows and columns seen for a full window ending here
  assign win_full = (row_cnt >= ROW_W'(WIN - 1)) && (col_cnt >= COL_W'(WIN - 1));

  // raster position, wraps at frame end
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (pix_valid_i) begin
      if (col_end) begin
        col_cnt <= '0;
        if (row_end) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // rows move up one memory per pixel, new pixel enters the newest row
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      for (int k = 0; k < WIN - 2; k++) begin
        row_mem[k][col_cnt] <= row_mem[k+1][col_cnt];
      end
      row_mem[WIN-2][col_cnt] <= pix_i;
      for (int k = 0; k < WIN - 1; k++) begin
        col_o[k] <= row_mem[k][col_cnt];
      end
      col_o[WIN-1] <= pix_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      col_valid_o <= 1'b0;
      win_full_o  <= 1'b0;
      last_o      <= 1'b0;
    end else begin
      col_valid_o <= pix_valid_i;
      win_full_o  <= pix_valid_i && win_full;
      last_o      <= pix_valid_i && col_end && row_end;
    end
  end

endmodule

//--- nird_properties.sv
module nird_properties
  import descriptor_pkg::*;
(
    input clk,
    input rst_n_i,
    input code_t ni_o,
    input code_t rd_o,
    input desc_valid_o,
    input frame_done_o
);

  // strobes stay quiet while reset is held
  quiet_in_reset: assert property (
    @(posedge clk) !rst_n_i |-> !desc_valid_o && !frame_done_o
  ) else $error("desc_valid_o or frame_done_o high during reset");

  // the frame end marks a real descriptor
  done_with_valid: assert property (
    @(posedge clk) disable iff (!rst_n_i) frame_done_o |-> desc_valid_o
  ) else $error("frame_done_o high without desc_valid_o");

  codes_in_range: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      desc_valid_o |-> (ni_o <= NONUNIFORM_CODE) && (rd_o <= NONUNIFORM_CODE)
  ) else $error("code above the non-uniform code while valid");

endmodule

bind nird_top nird_properties nird_properties_i (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .ni_o(ni_o),
    .rd_o(rd_o),
    .desc_valid_o(desc_valid_o),
    .frame_done_o(frame_done_o)
);

//--- nird_top.sv
module nird_top
  import image_pkg::*;
  import descriptor_pkg::*;
(
    input clk,
    input rst_n_i,
    input pixel_t pix_i,
    input pix_valid_i,
    output code_t ni_o,
    output code_t rd_o,
    output logic desc_valid_o,
    output logic frame_done_o
);

  column_t col;
  logic col_valid;
  logic win_full;
  logic col_last;

  window_t win;
  logic win_valid;
  logic frame_last;

  line_buffer line_buffer_i (
      .clk(clk),
      .rst_n_i(rst_n_i),
      .pix_i(pix_i),
      .pix_valid_i(pix_valid_i),
      .col_o(col),
      .col_valid_o(col_valid),
      .win_full_o(win_full),
      .last_o(col_last)
  );

  window_regs window_regs_i (
      .clk(clk),
      .rst_n_i(rst_n_i),
      .col_i(col),
      .col_valid_i(col_valid),
      .win_full_i(win_full),
      .last_i(col_last),
      .win_o(win),
      .win_valid_o(win_valid),
      .frame_last_o(frame_last)
  );

  // two pipeline stages, codes follow win_valid by two cycles
  descriptor_calc descriptor_calc_i (
      .clk(clk),
      .rst_n_i(rst_n_i),
      .win_i(win),
      .win_valid_i(win_valid),
      .frame_last_i(frame_last),
      .ni_o(ni_o),
      .rd_o(rd_o),
      .desc_valid_o(desc_valid_o),
      .frame_done_o(frame_done_o)
  );

endmodule

//--- run.sh
#!/bin/sh
# compile and run the NI/RD testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_nird -f sources.f -o sim_nird
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_nird > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  exit 0
fi
exit 1

//--- sources.f
image_pkg.sv
descriptor_pkg.sv
line_buffer.sv
window_regs.sv
descriptor_calc.sv
nird_top.sv
nird_properties.sv
tb_nird.sv

//--- tb_nird.sv
module tb_nird
  import image_pkg::*;
  import descriptor_pkg::*;
();

  localparam logic [31:0] SEED = 32'h133121da;
  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DELAY = 10;
  localparam int RESET_CYCLES = 8;
  localparam int LATENCY = 4;
  localparam int NUM_FRAMES = 4;
  localparam int PER_FRAME = (ROWS - (WIN - 1)) * (COLS - (WIN - 1));
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * COLS * ROWS * 3 + 200;

  logic clk;
  logic rst_n_i;
  pixel_t pix_i;
  logic pix_valid_i;
  code_t ni_o;
  code_t rd_o;
  logic desc_valid_o;
  logic frame_done_o;

  pixel_t frame_img[ROWS][COLS];

  // expected descriptors in raster order of their centre pixels
  code_t exp_ni_q[$];
  code_t exp_rd_q[$];
  logic exp_last_q[$];
  int exp_cycle_q[$];

  int cycle_cnt = 0;
  int desc_count = 0;
  int frame_desc = 0;
  int done_count = 0;
  int code_errors = 0;
  int flag_errors = 0;
  int timing_errors = 0;
  int other_errors = 0;

  nird_top dut_i (
      .clk(clk),
      .rst_n_i(rst_n_i),
      .pix_i(pix_i),
      .pix_valid_i(pix_valid_i),
      .ni_o(ni_o),
      .rd_o(rd_o),
      .desc_valid_o(desc_valid_o),
      .frame_done_o(frame_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // uniform patterns give their count of ones
  function automatic code_t uniform_code(input pattern_t p);
    int trans;
    int ones;
    trans = 0;
    ones = 0;
    for (int k = 0; k < NUM_SAMPLES; k++) begin
      if (p[k] != p[(k + 1) % NUM_SAMPLES]) trans++;
      if (p[k]) ones++;
    end
    if (trans <= MAX_TRANSITIONS) begin
      return code_t'(ones);
    end
    return NONUNIFORM_CODE;
  endfunction

  // sample order E, NE, N, NW, W, SW, S, SE with north towards row 0
  function automatic void ref_codes(input int y, input int x, output code_t ni,
                                    output code_t rd);
    int dy[NUM_SAMPLES] = '{0, -1, -1, -1, 0, 1, 1, 1};
    int dx[NUM_SAMPLES] = '{1, 1, 0, -1, -1, -1, 0, 1};
    int sum;
    int outer;
    int inner;
    pattern_t ni_pat;
    pattern_t rd_pat;
    sum = 0;
    for (int r = -RADIUS; r <= RADIUS; r++) begin
      for (int c = -RADIUS; c <= RADIUS; c++) begin
        sum += int'(frame_img[y+r][x+c]);
      end
    end
    for (int k = 0; k < NUM_SAMPLES; k++) begin
      outer = int'(frame_img[y+RADIUS*dy[k]][x+RADIUS*dx[k]]);
      inner = int'(frame_img[y+dy[k]][x+dx[k]]);
      ni_pat[k] = (outer * WIN_AREA >= sum);
      rd_pat[k] = (outer >= inner);
    end
    ni = uniform_code(ni_pat);
    rd = uniform_code(rd_pat);
  endfunction

  task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic fill_flat(input pixel_t value);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        frame_img[r][c] = value;
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        frame_img[r][c] = pixel_t'($urandom_range(255, 0));
      end
    end
  endtask

  // a flat frame has every sample equal to the mean and to its inner sample
  task automatic queue_expected(input logic flat);
    code_t ni;
    code_t rd;
    for (int r = WIN - 1; r < ROWS; r++) begin
      for (int c = WIN - 1; c < COLS; c++) begin
        if (flat) begin
          ni = 4'd8;
          rd = 4'd8;
        end else begin
          ref_codes(r - RADIUS, c - RADIUS, ni, rd);
        end
        exp_ni_q.push_back(ni);
        exp_rd_q.push_back(rd);
        exp_last_q.push_back(r == ROWS - 1 && c == COLS - 1);
      end
    end
  endtask

  task automatic drive_frame(input int max_gap);
    int gap;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        pix_i = frame_img[r][c];
        pix_valid_i = 1'b1;
        if (r >= WIN - 1 && c >= WIN - 1) exp_cycle_q.push_back(cycle_cnt + LATENCY);
        step();
        pix_valid_i = 1'b0;
        gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
        repeat (gap) step();
      end
    end
  endtask

  task automatic check_code(input string what, input code_t got, input code_t exp);
    if (got !== exp) begin
      code_errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    if (got != exp) begin
      timing_errors++;
      $display("FAIL %0t: %s came in cycle %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("error counts: code %0d, flag %0d, timing %0d, other %0d",
             code_errors, flag_errors, timing_errors, other_errors);
    if (code_errors + flag_errors + timing_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // outputs sampled at the falling edge
  always @(negedge clk) begin
    code_t e_ni;
    code_t e_rd;
    logic e_last;
    int e_cycle;
    if (rst_n_i) begin
      if (desc_valid_o) begin
        if (exp_ni_q.size() == 0 || exp_cycle_q.size() == 0) begin
          other_errors++;
          $display("descriptor at time %0t with no expected entry left", $time);
        end else begin
          e_ni = exp_ni_q.pop_front();
          e_rd = exp_rd_q.pop_front();
          e_last = exp_last_q.pop_front();
          e_cycle = exp_cycle_q.pop_front();
          check_code($sformatf("NI of descriptor %0d", desc_count), ni_o, e_ni);
          check_code($sformatf("RD of descriptor %0d", desc_count), rd_o, e_rd);
          check_flag($sformatf("frame_done_o at descriptor %0d", desc_count),
                     frame_done_o, e_last);
          check_latency($sformatf("descriptor %0d", desc_count), cycle_cnt, e_cycle);
        end
        desc_count++;
        frame_desc++;
      end else begin
        check_flag("frame_done_o without a descriptor", frame_done_o, 1'b0);
      end
      // frames delimited by the DUT's own end pulse
      if (frame_done_o) begin
        done_count++;
        if (frame_desc != PER_FRAME) begin
          other_errors++;
          $display("frame ended after %0d descriptors instead of %0d",
                   frame_desc, PER_FRAME);
        end
        frame_desc = 0;
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) @(posedge clk);
    other_errors++;
    $display("timeout after %0d cycles with %0d descriptors still expected",
             cycle_cnt, exp_ni_q.size());
    finish_run();
  end

  initial begin
    void'($urandom(SEED));
    rst_n_i = 1'b0;
    pix_i = '0;
    pix_valid_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    // idle, nothing may come out
    repeat (10) step();

    fill_flat(8'h5a);
    queue_expected(1'b1);
    drive_frame(0);

    fill_random();
    queue_expected(1'b0);
    drive_frame(0);

    // two gapped frames back to back, no reset in between
    for (int f = 0; f < NUM_FRAMES - 2; f++) begin
      fill_random();
      queue_expected(1'b0);
      drive_frame(2);
    end

    while (exp_ni_q.size() != 0) step();
    repeat (2 * LATENCY) step();

    if (desc_count != NUM_FRAMES * PER_FRAME) begin
      other_errors++;
      $display("received %0d descriptors instead of %0d", desc_count,
               NUM_FRAMES * PER_FRAME);
    end
    if (done_count != NUM_FRAMES) begin
      other_errors++;
      $display("frame_done_o pulsed %0d times for %0d frames", done_count, NUM_FRAMES);
    end
    finish_run();
  end

endmodule

//--- window_regs.sv
module window_regs
  import image_pkg::*;
(
    input clk,
    input rst_n_i,
    input column_t col_i,
    input col_valid_i,
    input win_full_i,
    input last_i,
    output window_t win_o,
    output logic win_valid_o,
    output logic frame_last_o
);

  logic take_win;

  // only columns that close a complete window produce an output
  assign take_win = col_valid_i && win_full_i;

  // every column shifts in, also the ones near the frame edge
  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      for (int c = 0; c < WIN - 1; c++) begin
        win_o[c] <= win_o[c+1];
      end
      win_o[WIN-1] <= col_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      win_valid_o  <= 1'b0;
      frame_last_o <= 1'b0;
    end else begin
      win_valid_o  <= take_win;
      frame_last_o <= take_win && last_i;
    end
  end

endmodule
